// File: include/os_filter_cfg.svh
`ifndef OS_FILTER_CFG_SVH
`define OS_FILTER_CFG_SVH

// Channel count and channel number width
`define OSF_N_CHAN   8
`define OSF_W_CHAN   3

// Signed sample width
`define OSF_W_DATA   18

// Oversample setting, os runs 0 to 7
`define OSF_W_OS     3

// Count must hold 2^7
`define OSF_W_COUNT  8

// Data width plus largest os, no overflow possible
`define OSF_W_SUM    25

// Register write bus
`define OSF_W_ADDR   16
`define OSF_W_WDATA  32
`define OSF_ADDR_OS  16'h0010
`define OSF_ADDR_CLR 16'h0011

// Oversample value after reset
`define OSF_OS_INIT  2

`endif

// File: src/os_filter_pkg.sv
`include "os_filter_cfg.svh"

package os_filter_pkg;

    // Vector types with a meaning
    typedef logic        [`OSF_W_CHAN-1:0]  chan_t;
    typedef logic signed [`OSF_W_DATA-1:0]  sample_t;
    typedef logic signed [`OSF_W_SUM-1:0]   sum_t;
    typedef logic        [`OSF_W_COUNT-1:0] count_t;
    typedef logic        [`OSF_W_OS-1:0]    os_t;
    typedef logic        [`OSF_N_CHAN-1:0]  chan_mask_t;

    // Sample word, used at input and output
    typedef struct packed {
        logic    dv;
        chan_t   chan;
        sample_t data;
    } in_word_t;

    // Stage 2 to stage 3
    typedef struct packed {
        logic   dv;
        chan_t  chan;
        sum_t   sum;
        count_t count;
        os_t    os;
    } acc_word_t;

    // Writeback into the state memory
    typedef struct packed {
        logic   en;
        chan_t  chan;
        sum_t   sum;
        count_t count;
    } wb_word_t;

endpackage

// File: src/os_filter_ctrl.sv
`timescale 1ns/1ps

`include "os_filter_cfg.svh"

module os_filter_ctrl import os_filter_pkg::*; (
    input  logic                    clk_in,
    input  logic                    rst,

    // Register write bus
    input  logic                    wr_en,
    input  logic [`OSF_W_ADDR-1:0]  wr_addr,
    // Channel field is as wide as the address field
    input  logic [`OSF_W_ADDR-1:0]  wr_chan,
    input  logic [`OSF_W_WDATA-1:0] wr_data,

    // Per-channel settings towards the datapath
    output os_t                     os_table [`OSF_N_CHAN],
    output chan_mask_t              clr_mask
);

    // --------------------------------------------------
    // Write decode
    // --------------------------------------------------

    logic  wr_ok;
    logic  wr_os;
    logic  wr_clr;
    chan_t wr_idx;

    // Out-of-range channels are dropped here
    assign wr_ok  = wr_en && (wr_chan < `OSF_N_CHAN);
    assign wr_idx = wr_chan[`OSF_W_CHAN-1:0];

    assign wr_os  = wr_ok && (wr_addr == `OSF_ADDR_OS);
    // Clear only when bit 0 is set
    assign wr_clr = wr_ok && (wr_addr == `OSF_ADDR_CLR) && wr_data[0];

    // --------------------------------------------------
    // Oversample table
    // --------------------------------------------------

    always_ff @(posedge clk_in) begin
        if (rst) begin
            for (int i = 0; i < `OSF_N_CHAN; i++) begin
                os_table[i] <= os_t'(`OSF_OS_INIT);
            end
        end else if (wr_os) begin
            // New os seen by stage 2 from the next edge on
            os_table[wr_idx] <= wr_data[`OSF_W_OS-1:0];
        end
    end

    // --------------------------------------------------
    // Clear requests
    // --------------------------------------------------

    // One-cycle pulse per write
    always_ff @(posedge clk_in) begin
        if (rst) begin
            clr_mask <= '0;
        end else begin
            clr_mask <= '0;
            if (wr_clr) begin
                clr_mask[wr_idx] <= 1'b1;
            end
        end
    end

endmodule

// File: src/os_state_mem.sv
`timescale 1ns/1ps

`include "os_filter_cfg.svh"

module os_state_mem import os_filter_pkg::*; (
    input  logic       clk_in,
    input  logic       rst,

    // Read port, combinational
    input  chan_t      rd_chan,
    output sum_t       rd_sum,
    output count_t     rd_count,

    // Writeback from stage 3
    input  wb_word_t   wb,

    // Pending clears
    input  chan_mask_t clr_mask
);

    // --------------------------------------------------
    // Per-channel state
    // --------------------------------------------------

    sum_t   sum_mem   [`OSF_N_CHAN];
    count_t count_mem [`OSF_N_CHAN];

    // Fetch for the channel entering stage 1
    assign rd_sum   = sum_mem[rd_chan];
    assign rd_count = count_mem[rd_chan];

    // --------------------------------------------------
    // Writeback and zeroing
    // --------------------------------------------------

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < `OSF_N_CHAN; i++) begin
            if (rst || clr_mask[i]) begin
                // Clear beats a writeback to the same channel
                sum_mem[i]   <= '0;
                count_mem[i] <= '0;
            end else if (wb.en && (wb.chan == chan_t'(i))) begin
                sum_mem[i]   <= wb.sum;
                count_mem[i] <= wb.count;
            end
        end
    end

endmodule

// File: src/os_accum.sv
`timescale 1ns/1ps

`include "os_filter_cfg.svh"

module os_accum import os_filter_pkg::*; (
    input  logic       clk_in,
    input  logic       rst,

    // Incoming sample
    input  in_word_t   in_word,

    // State memory read port
    output chan_t      rd_chan,
    input  sum_t       rd_sum,
    input  count_t     rd_count,

    // Settings from control
    input  os_t        os_table [`OSF_N_CHAN],
    input  chan_mask_t clr_mask,

    // Pending writeback, watched for forwarding
    input  wb_word_t   wb,

    // To stage 3
    output acc_word_t  acc_word
);

    in_word_t p1_word;
    sum_t     p1_sum;
    count_t   p1_count;

    logic     fwd_in;
    logic     fwd_p1;
    sum_t     base_sum;
    count_t   base_count;

    // --------------------------------------------------
    // Stage 1, fetch
    // --------------------------------------------------

    assign rd_chan = in_word.chan;

    // Writeback lands on the same edge, memory still stale
    assign fwd_in = wb.en && (wb.chan == in_word.chan);

    always_ff @(posedge clk_in) begin
        if (rst || clr_mask[in_word.chan]) begin
            p1_word.dv <= 1'b0;
        end else begin
            p1_word.dv <= in_word.dv;
        end
        p1_word.chan <= in_word.chan;
        p1_word.data <= in_word.data;
        p1_sum       <= fwd_in ? wb.sum : rd_sum;
        p1_count     <= fwd_in ? wb.count : rd_count;
    end

    // --------------------------------------------------
    // Stage 2, accumulate
    // --------------------------------------------------

    // Back-to-back same channel, take the newer state
    assign fwd_p1     = wb.en && (wb.chan == p1_word.chan);
    assign base_sum   = fwd_p1 ? wb.sum : p1_sum;
    assign base_count = fwd_p1 ? wb.count : p1_count;

    always_ff @(posedge clk_in) begin
        if (rst || clr_mask[p1_word.chan]) begin
            acc_word.dv <= 1'b0;
        end else begin
            acc_word.dv <= p1_word.dv;
        end
        acc_word.chan  <= p1_word.chan;
        // Sign-extended add, width covers 2^7 samples
        acc_word.sum   <= base_sum + sum_t'(p1_word.data);
        acc_word.count <= base_count + 1'b1;
        // os picked up here, after any write on the edge before
        acc_word.os    <= os_table[p1_word.chan];
    end

endmodule

// File: src/os_decimate.sv
`timescale 1ns/1ps

`include "os_filter_cfg.svh"

module os_decimate import os_filter_pkg::*; (
    input  logic       clk_in,
    input  logic       rst,

    // From stage 2
    input  acc_word_t  acc_word,
    input  chan_mask_t clr_mask,

    // Writeback to state memory and stage 1/2 forwarding
    output wb_word_t   wb,

    // Averaged output
    output in_word_t   out_word
);

    logic done;
    sum_t sum_div;

    // --------------------------------------------------
    // Block completion and divide
    // --------------------------------------------------

    // Count reaches 2^os exactly when bit os goes high
    assign done    = acc_word.count[acc_word.os];
    // Arithmetic shift, floor for negative sums
    assign sum_div = acc_word.sum >>> acc_word.os;

    // --------------------------------------------------
    // Writeback
    // --------------------------------------------------

    always_comb begin
        wb.en    = acc_word.dv;
        wb.chan  = acc_word.chan;
        // Restart from zero after a full block
        wb.sum   = done ? '0 : acc_word.sum;
        wb.count = done ? '0 : acc_word.count;
    end

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------

    always_ff @(posedge clk_in) begin
        if (rst || clr_mask[acc_word.chan]) begin
            out_word.dv <= 1'b0;
        end else begin
            out_word.dv <= acc_word.dv && done;
        end
        out_word.chan <= acc_word.chan;
        // Truncate to sample width
        out_word.data <= sum_div[`OSF_W_DATA-1:0];
    end

endmodule

// File: src/os_filter_top.sv
`timescale 1ns/1ps

`include "os_filter_cfg.svh"

module os_filter_top import os_filter_pkg::*; (
    input  logic                    clk_in,
    input  logic                    rst,

    // Sample input
    input  logic                    dv_in,
    input  chan_t                   chan_in,
    input  sample_t                 data_in,

    // Register write bus
    input  logic                    wr_en,
    input  logic [`OSF_W_ADDR-1:0]  wr_addr,
    input  logic [`OSF_W_ADDR-1:0]  wr_chan,
    input  logic [`OSF_W_WDATA-1:0] wr_data,

    // Averaged output
    output logic                    dv_out,
    output chan_t                   chan_out,
    output sample_t                 data_out
);

    in_word_t   in_word;
    in_word_t   out_word;
    acc_word_t  acc_word;
    wb_word_t   wb;
    os_t        os_table [`OSF_N_CHAN];
    chan_mask_t clr_mask;
    chan_t      rd_chan;
    sum_t       rd_sum;
    count_t     rd_count;

    // --------------------------------------------------
    // Struct packing
    // --------------------------------------------------

    assign in_word = '{dv: dv_in, chan: chan_in, data: data_in};

    assign dv_out   = out_word.dv;
    assign chan_out = out_word.chan;
    assign data_out = out_word.data;

    // --------------------------------------------------
    // Control and datapath
    // --------------------------------------------------

    os_filter_ctrl u_ctrl (
        .clk_in   (clk_in),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_chan  (wr_chan),
        .wr_data  (wr_data),
        .os_table (os_table),
        .clr_mask (clr_mask)
    );

    os_state_mem u_state_mem (
        .clk_in   (clk_in),
        .rst      (rst),
        .rd_chan  (rd_chan),
        .rd_sum   (rd_sum),
        .rd_count (rd_count),
        .wb       (wb),
        .clr_mask (clr_mask)
    );

    // Stages 1 and 2
    os_accum u_accum (
        .clk_in   (clk_in),
        .rst      (rst),
        .in_word  (in_word),
        .rd_chan  (rd_chan),
        .rd_sum   (rd_sum),
        .rd_count (rd_count),
        .os_table (os_table),
        .clr_mask (clr_mask),
        .wb       (wb),
        .acc_word (acc_word)
    );

    // Stage 3
    os_decimate u_decimate (
        .clk_in   (clk_in),
        .rst      (rst),
        .acc_word (acc_word),
        .clr_mask (clr_mask),
        .wb       (wb),
        .out_word (out_word)
    );

endmodule

// File: tb/os_filter_properties.sv
`timescale 1ns/1ps

module os_filter_properties import os_filter_pkg::*; (
    input logic  clk_in,
    input logic  rst,
    input logic  dv_in,
    input chan_t chan_in,
    input logic  dv_out,
    input chan_t chan_out
);

    // Reset flushes the output register
    a_reset_flush: assert property (
        @(posedge clk_in) rst |=> !dv_out
    ) else $error("dv_out high in the cycle after reset");

    // Output keeps the channel of the sample it came from
    a_chan_match: assert property (
        @(posedge clk_in) disable iff (rst)
        dv_out |-> (chan_out == $past(chan_in, 3))
    ) else $error("chan_out differs from the channel accepted three cycles earlier");

    // Three stages from an accepted sample to dv_out
    a_latency: assert property (
        @(posedge clk_in) disable iff (rst)
        dv_out |-> $past(dv_in, 3)
    ) else $error("dv_out without a sample three cycles earlier");

endmodule

// File: tb/os_filter_tb.sv
`timescale 1ns/1ps

`include "os_filter_cfg.svh"

module os_filter_tb import os_filter_pkg::*; ();

    localparam logic [1:0] K_SAMPLE = 2'd0;
    localparam logic [1:0] K_WRITE  = 2'd1;
    localparam logic [1:0] K_RESET  = 2'd2;
    // Cycles allowed for in-flight samples to reach dv_out
    localparam int DRAIN_MAX  = 8;
    localparam int PIPE_DEPTH = 3;

    // One row of the stimulus table
    typedef struct packed {
        logic [1:0]                  kind;
        logic [2:0]                  test;
        logic [1:0]                  gap;
        logic [`OSF_W_ADDR-1:0]      addr;
        logic [`OSF_W_ADDR-1:0]      chan;
        logic [`OSF_W_WDATA-1:0]     data;
    } entry_t;

    logic                    clk_in;
    logic                    rst;
    logic                    dv_in;
    chan_t                   chan_in;
    sample_t                 data_in;
    logic                    wr_en;
    logic [`OSF_W_ADDR-1:0]  wr_addr;
    logic [`OSF_W_ADDR-1:0]  wr_chan;
    logic [`OSF_W_WDATA-1:0] wr_data;
    logic                    dv_out;
    chan_t                   chan_out;
    sample_t                 data_out;

    entry_t   table_q [$];
    in_word_t exp_q [$];

    // Reference model state
    longint acc_sum [`OSF_N_CHAN];
    int     acc_cnt [`OSF_N_CHAN];
    int     ch_os   [`OSF_N_CHAN];
    int     last_push_cyc;
    int     last_push_chan;

    int     apply_cyc;
    int     cycles;
    int     cycle_limit;
    int     errors;
    int     checks;
    int     test_errors;
    int     test_checks;
    int     tests_run;
    string  test_name [7] = '{"", "reset os of 2", "os 0 and 5, negative data",
                              "interleaved channels", "clear", "ignored writes",
                              "reset mid-run"};

    os_filter_top dut_i (.*);

    bind os_filter_top os_filter_properties u_props (
        .clk_in   (clk_in),
        .rst      (rst),
        .dv_in    (dv_in),
        .chan_in  (chan_in),
        .dv_out   (dv_out),
        .chan_out (chan_out)
    );

    always #10 clk_in = ~clk_in;

    // --------------------------------------------------
    // Table building
    // --------------------------------------------------

    function automatic entry_t sample_entry(int test, int ch, int data, int gap);
        entry_t e;
        e      = '0;
        e.kind = K_SAMPLE;
        e.test = test;
        e.gap  = gap;
        e.chan = ch;
        e.data = data;
        return e;
    endfunction

    function automatic entry_t write_entry(int test, int addr, int ch, int data, int gap);
        entry_t e;
        e      = sample_entry(test, ch, data, gap);
        e.kind = K_WRITE;
        e.addr = addr;
        return e;
    endfunction

    function automatic int rand_data();
        // Full signed sample range
        return int'(sample_t'($urandom));
    endfunction

    function automatic void build_table();
        int mix [16] = '{4, 4, 5, 4, 5, 5, 4, 4, 5, 5, 4, 5, 4, 4, 5, 5};
        entry_t rst_e;
        // Two blocks of four on channel 0, random gaps
        for (int i = 0; i < 8; i++) begin
            table_q.push_back(sample_entry(1, 0, rand_data(), $urandom_range(0, 2)));
        end
        // os 0 passes samples through
        table_q.push_back(write_entry(2, `OSF_ADDR_OS, 1, 0, 0));
        for (int i = 0; i < 3; i++) begin
            table_q.push_back(sample_entry(2, 1, rand_data(), 0));
        end
        // os 5, 32 negative samples back to back
        table_q.push_back(write_entry(2, `OSF_ADDR_OS, 2, 5, 1));
        for (int i = 0; i < 32; i++) begin
            table_q.push_back(sample_entry(2, 2, -int'($urandom_range(1, 40000)), 0));
        end
        // Sum -9, floor average -3
        table_q.push_back(sample_entry(2, 3, -5, 0));
        table_q.push_back(sample_entry(2, 3, -6, 0));
        table_q.push_back(sample_entry(2, 3, 2, 0));
        table_q.push_back(sample_entry(2, 3, 0, 1));
        // Same channel on consecutive cycles needs forwarding
        foreach (mix[i]) begin
            table_q.push_back(sample_entry(3, mix[i], rand_data(), 0));
        end
        // Partial block on 6 dropped, channel 7 keeps one sample
        table_q.push_back(sample_entry(4, 6, rand_data(), 0));
        table_q.push_back(sample_entry(4, 6, rand_data(), 0));
        table_q.push_back(sample_entry(4, 7, rand_data(), 0));
        table_q.push_back(write_entry(4, `OSF_ADDR_CLR, 6, 1, 1));
        for (int i = 0; i < 4; i++) begin
            table_q.push_back(sample_entry(4, 6, rand_data(), 0));
        end
        // Block completed one cycle before the clear never shows up
        for (int i = 0; i < 4; i++) begin
            table_q.push_back(sample_entry(4, 6, rand_data(), 0));
        end
        table_q.push_back(write_entry(4, `OSF_ADDR_CLR, 6, 1, 1));
        for (int i = 0; i < 3; i++) begin
            table_q.push_back(sample_entry(4, 7, rand_data(), 1));
        end
        for (int i = 0; i < 4; i++) begin
            table_q.push_back(sample_entry(4, 6, rand_data(), 0));
        end
        // Out-of-range channels, unknown address, clear without bit 0
        table_q.push_back(write_entry(5, `OSF_ADDR_OS, 16'h0008, 0, 0));
        table_q.push_back(write_entry(5, `OSF_ADDR_OS, 16'h0100, 0, 0));
        table_q.push_back(write_entry(5, 16'h0012, 0, 0, 0));
        table_q.push_back(sample_entry(5, 5, rand_data(), 0));
        table_q.push_back(sample_entry(5, 5, rand_data(), 0));
        table_q.push_back(write_entry(5, `OSF_ADDR_CLR, 5, 32'h2, 0));
        table_q.push_back(write_entry(5, `OSF_ADDR_CLR, 16'h000d, 1, 0));
        table_q.push_back(sample_entry(5, 5, rand_data(), 0));
        table_q.push_back(sample_entry(5, 5, rand_data(), 0));
        for (int i = 0; i < 4; i++) begin
            table_q.push_back(sample_entry(5, 0, rand_data(), 0));
        end
        // Partial sum on 4 lost to reset, os of 1 and 2 back to 2
        table_q.push_back(sample_entry(6, 4, rand_data(), 0));
        table_q.push_back(sample_entry(6, 4, rand_data(), 0));
        rst_e      = '0;
        rst_e.kind = K_RESET;
        rst_e.test = 6;
        table_q.push_back(rst_e);
        for (int i = 0; i < 12; i++) begin
            table_q.push_back(sample_entry(6, (i < 4) ? 4 : ((i < 8) ? 1 : 2), rand_data(), 0));
        end
    endfunction

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    function automatic void reset_reference();
        for (int i = 0; i < `OSF_N_CHAN; i++) begin
            acc_sum[i] = 0;
            acc_cnt[i] = 0;
            ch_os[i]   = `OSF_OS_INIT;
        end
        last_push_cyc = -10;
    endfunction

    function automatic void predict_sample(int ch, sample_t d);
        in_word_t want;
        acc_sum[ch] += d;
        acc_cnt[ch]++;
        // Block ends after 2^os samples
        if (acc_cnt[ch] == (1 << ch_os[ch])) begin
            want.dv        = 1'b1;
            want.chan      = ch;
            want.data      = sample_t'(acc_sum[ch] >>> ch_os[ch]);
            exp_q.push_back(want);
            last_push_cyc  = apply_cyc;
            last_push_chan = ch;
            acc_sum[ch]    = 0;
            acc_cnt[ch]    = 0;
        end
    endfunction

    function automatic void apply_write_rule(int addr, int ch, logic [`OSF_W_WDATA-1:0] d);
        if (ch < `OSF_N_CHAN) begin
            if (addr == `OSF_ADDR_OS) begin
                ch_os[ch] = d[`OSF_W_OS-1:0];
            end else if (addr == `OSF_ADDR_CLR && d[0]) begin
                // Sample one cycle back is flushed from stage 3 before output
                if (last_push_cyc == apply_cyc - 1 && last_push_chan == ch) begin
                    void'(exp_q.pop_back());
                end
                acc_sum[ch] = 0;
                acc_cnt[ch] = 0;
            end
        end
    endfunction

    // --------------------------------------------------
    // Driving
    // --------------------------------------------------

    task automatic next_cycle();
        @(posedge clk_in);
        #2;
        dv_in = 1'b0;
        wr_en = 1'b0;
        apply_cyc++;
    endtask

    task automatic pulse_reset();
        rst = 1'b1;
        next_cycle();
        next_cycle();
        rst = 1'b0;
    endtask

    task automatic drain_outputs();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_MAX) begin
            next_cycle();
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d expected outputs never appeared on dv_out", exp_q.size());
            errors++;
            test_errors++;
            exp_q.delete();
        end
    endtask

    task automatic apply_entry(input entry_t e);
        next_cycle();
        case (e.kind)
            K_SAMPLE: begin
                dv_in   = 1'b1;
                chan_in = e.chan[`OSF_W_CHAN-1:0];
                data_in = e.data[`OSF_W_DATA-1:0];
                predict_sample(e.chan, sample_t'(e.data));
            end
            K_WRITE: begin
                wr_en   = 1'b1;
                wr_addr = e.addr;
                wr_chan = e.chan;
                wr_data = e.data;
                apply_write_rule(e.addr, e.chan, e.data);
            end
            default: begin
                drain_outputs();
                pulse_reset();
                reset_reference();
            end
        endcase
        repeat (e.gap) begin
            next_cycle();
        end
    endtask

    function automatic void report_test(int t);
        $display("Test %0d (%s): %0d outputs checked, %0d errors",
                 t, test_name[t], test_checks, test_errors);
        tests_run++;
        test_checks = 0;
        test_errors = 0;
    endfunction

    // --------------------------------------------------
    // Output monitor and timeout
    // --------------------------------------------------

    // Mid-cycle, outputs settled
    always @(negedge clk_in) begin
        in_word_t want;
        if (dv_out === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                $display("Output on channel %0d arrived with nothing expected", chan_out);
                errors++;
                test_errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                checks++;
                test_checks++;
                assert (chan_out == want.chan) else begin
                    $display("[ERROR] chan_out: expected %h, got %h", want.chan, chan_out);
                    errors++;
                    test_errors++;
                end
                assert (data_out == want.data) else begin
                    $display("[ERROR] data_out: expected %h, got %h", want.data, data_out);
                    errors++;
                    test_errors++;
                end
            end
        end
    end

    always @(posedge clk_in) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("test failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        int cur_test;
        void'($urandom(32'h7041_a31b));
        clk_in    = 1'b0;
        rst       = 1'b1;
        dv_in     = 1'b0;
        chan_in   = '0;
        data_in   = '0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_chan   = '0;
        wr_data   = '0;
        cycles    = 0;
        apply_cyc = 0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        test_errors = 0;
        test_checks = 0;
        build_table();
        cycle_limit = table_q.size() * 3 + 50;
        reset_reference();
        pulse_reset();
        cur_test = table_q[0].test;
        foreach (table_q[i]) begin
            // Test boundary, wait for its last outputs
            if (table_q[i].test != cur_test) begin
                drain_outputs();
                report_test(cur_test);
                cur_test = table_q[i].test;
            end
            apply_entry(table_q[i]);
        end
        drain_outputs();
        // Room for any stray output
        repeat (PIPE_DEPTH) begin
            next_cycle();
        end
        report_test(cur_test);
        $display("Summary: %0d tests, %0d outputs checked, %0d errors",
                 tests_run, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
src/os_filter_pkg.sv
src/os_filter_ctrl.sv
src/os_state_mem.sv
src/os_accum.sv
src/os_decimate.sv
src/os_filter_top.sv
tb/os_filter_properties.sv
tb/os_filter_tb.sv

// File: Bender.yml
package:
  name: os_filter

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/os_filter_pkg.sv
      - src/os_filter_ctrl.sv
      - src/os_state_mem.sv
      - src/os_accum.sv
      - src/os_decimate.sv
      - src/os_filter_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/os_filter_properties.sv
      - tb/os_filter_tb.sv
